// File: flist.f
verilog/rv_exec_pkg.sv
verilog/key_lookup.sv
verilog/inst_decode.sv
verilog/alu.sv
verilog/gpr_file.sv
verilog/wb_arbiter.sv
verilog/exec_top.sv
testbench/tb_clkgen.sv
testbench/tb_exec_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, exit status is the test result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_exec_top -Mdir obj_dir -f flist.f \
  && ./obj_dir/Vtb_exec_top \
  || exit 1

// File: testbench/tb_exec_top.sv
/*
 * testbench for the rv64 execute slice
 * reference register and writeback model, directed and random stimulus
 */
`timescale 1ns/1ps

module tb_exec_top;
  import rv_exec_pkg::*;

  // about four cycles per random instruction plus the directed part
  localparam int n_random   = 300;
  localparam int max_cycles = 4 * (n_random + 200);

  // {bit 30, funct3} of the register ops, then funct3 of the immediate ops
  localparam logic [3:0] r_ops [9] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7};
  localparam logic [2:0] i_ops [4] = '{3'b000, 3'b100, 3'b110, 3'b111};

  logic                  clk;
  logic                  rst;
  logic                  inst_valid;
  logic [inst_w-1:0]     inst;
  logic                  ld_valid;
  logic [reg_addr_w-1:0] ld_rd;
  logic [xlen-1:0]       ld_data;
  logic                  busy;
  logic                  inst_illegal;
  logic                  wb_valid;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_data;

  // pending ALU commits hold {rd, data}
  logic [63:0] ref_regs [32];
  logic [68:0] pending_q [$];
  int          seed   = 91;
  int          cycles = 0;
  logic        taken;

  tb_clkgen clkgen_i (.clk(clk), .rst(rst));

  exec_top dut_i (.*);

  task automatic flag_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first failing check");
  endtask

  // register read as seen in this cycle with the write port bypassed
  function automatic logic [63:0] read_ref(input logic [4:0] addr, input logic wen,
                                           input logic [4:0] waddr, input logic [63:0] wdata);
    if (addr == 5'd0) begin
      return 64'd0;
    end
    if (wen && waddr == addr) begin
      return wdata;
    end
    return ref_regs[addr];
  endfunction

  // kind 0..8 register ops, 9..12 immediate ops, 13 LUI
  function automatic logic [31:0] encode(input int kind, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [19:0] low);
    if (kind < 9) begin
      return {1'b0, r_ops[kind][3], 5'b0, low[4:0], rs1, r_ops[kind][2:0], rd, opc_op};
    end
    if (kind < 13) begin
      return {low[11:0], rs1, i_ops[kind - 9], rd, opc_op_imm};
    end
    return {low, rd, opc_lui};
  endfunction

  // expected {legal, result} from the RV64I rules of the subset
  function automatic logic [64:0] ref_exec(input logic [31:0] ins, input logic [63:0] a,
                                           input logic [63:0] rs2_val);
    logic [63:0] b;
    logic [2:0]  f3;
    logic        imm_ok;
    f3     = ins[14:12];
    b      = (ins[6:0] == opc_op) ? rs2_val : {{52{ins[31]}}, ins[31:20]};
    imm_ok = (ins[6:0] == opc_op_imm) && (f3 inside {3'b100, 3'b110, 3'b111});
    if (ins[6:0] == opc_lui) begin
      return {1'b1, {32{ins[31]}}, ins[31:12], 12'h000};
    end
    // ADDI takes bit 30 as plain immediate data
    if (ins[6:0] == opc_op_imm && f3 == 3'b000) begin
      return {1'b1, a + b};
    end
    if (ins[6:0] != opc_op && !imm_ok) begin
      return {1'b0, 64'd0};
    end
    case ({ins[30], f3})
      4'b0000: return {1'b1, a + b};
      4'b1000: return {1'b1, a - b};
      4'b0001: return {1'b1, a << b[5:0]};
      4'b0010: return {1'b1, 63'd0, $signed(a) < $signed(b)};
      4'b0011: return {1'b1, 63'd0, a < b};
      4'b0100: return {1'b1, a ^ b};
      4'b0101: return {1'b1, a >> b[5:0]};
      4'b0110: return {1'b1, a | b};
      4'b0111: return {1'b1, a & b};
      default: return {1'b0, 64'd0};
    endcase
  endfunction

  // drive one cycle, check at the falling edge and advance the model
  task automatic drive_cycle(input logic iv, input logic [31:0] ins, input logic lv,
                             input logic [4:0] lrd, input logic [63:0] ldata,
                             output logic accepted);
    logic        slot_v;
    logic        exp_busy;
    logic        exp_wen;
    logic [4:0]  exp_rd;
    logic [63:0] exp_data;
    logic [64:0] res;
    @(posedge clk);
    #1;
    inst_valid = iv;
    inst       = ins;
    ld_valid   = lv;
    ld_rd      = lrd;
    ld_data    = ldata;
    @(negedge clk);
    slot_v   = pending_q.size() != 0;
    exp_busy = slot_v && lv;
    exp_wen  = slot_v || lv;
    exp_rd   = 5'd0;
    exp_data = 64'd0;
    if (lv) begin
      exp_rd   = lrd;
      exp_data = ldata;
    end else if (slot_v) begin
      exp_rd   = pending_q[0][68:64];
      exp_data = pending_q[0][63:0];
    end
    accepted = iv && !exp_busy;
    res = ref_exec(ins, read_ref(ins[19:15], exp_wen, exp_rd, exp_data),
                   read_ref(ins[24:20], exp_wen, exp_rd, exp_data));
    assert (busy == exp_busy)
      else flag_error($sformatf("busy is %b, expected %b", busy, exp_busy));
    assert (inst_illegal == (accepted && !res[64]))
      else flag_error($sformatf("inst_illegal is %b for inst %h", inst_illegal, ins));
    assert (wb_valid == exp_wen)
      else flag_error($sformatf("wb_valid is %b, expected %b", wb_valid, exp_wen));
    assert (!exp_wen || (wb_rd == exp_rd && wb_data == exp_data))
      else flag_error($sformatf("commit x%0d = %h, expected x%0d = %h",
                                wb_rd, wb_data, exp_rd, exp_data));
    // state after the coming edge
    if (exp_wen && exp_rd != 5'd0) begin
      ref_regs[exp_rd] = exp_data;
    end
    if (slot_v && !lv) begin
      pending_q.delete(0);
    end
    if (accepted && res[64]) begin
      pending_q.push_back({ins[11:7], res[63:0]});
    end
  endtask

  // hold the instruction until accepted with random loads meanwhile
  task automatic issue(input logic [31:0] ins, input int load_pct);
    logic acc;
    logic lv;
    acc = 1'b0;
    while (!acc) begin
      lv = ($unsigned($random(seed)) % 100) < load_pct;
      drive_cycle(1'b1, ins, lv, 5'($random(seed)), {$random(seed), $random(seed)}, acc);
    end
  endtask

  // a held result only waits behind a load on the write port
  assert property (@(posedge clk) disable iff (rst) busy |-> ld_valid && wb_valid)
    else flag_error("busy high without a load on the write port");

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: the test did not finish within %0d cycles", max_cycles);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  initial begin
    inst_valid = 1'b0;
    inst       = '0;
    ld_valid   = 1'b0;
    ld_rd      = '0;
    ld_data    = '0;
    // idle outputs through reset and the first cycle after it
    do begin
      @(negedge clk);
      assert (!busy && !wb_valid && !inst_illegal)
        else flag_error("busy, wb_valid or inst_illegal high around reset");
    end while (rst);

    // every register, x0 too, written through the load port
    for (int r = 0; r < 32; r++) begin
      drive_cycle(1'b0, '0, 1'b1, 5'(r), {$random(seed), $random(seed)}, taken);
    end

    // each operation once with bit 30 clear on the immediate forms
    for (int k = 0; k < 14; k++) begin
      issue(encode(k, 5'($random(seed)), 5'($random(seed)), 20'($random(seed)) & 20'hffbff), 0);
    end

    // x0 as destination, then as source
    issue(encode(9, 5'd0, 5'd3, 20'd7), 0);
    issue(encode(0, 5'd8, 5'd0, 20'd3), 0);
    issue(encode(4, 5'd8, 5'd0, 20'd3), 0);

    // dependent pair, then a source written by a load in the same cycle
    issue(encode(9, 5'd5, 5'd1, 20'd5), 0);
    issue(encode(0, 5'd6, 5'd5, 20'd5), 0);
    drive_cycle(1'b0, '0, 1'b0, 5'd0, 64'd0, taken);
    drive_cycle(1'b1, encode(0, 5'd7, 5'd12, 20'd1), 1'b1, 5'd12,
                {$random(seed), $random(seed)}, taken);

    // loads hold the port while a result waits and the next instruction stalls
    issue(encode(1, 5'd9, 5'd1, 20'd2), 0);
    for (int k = 0; k < 4; k++) begin
      drive_cycle(1'b1, encode(0, 5'd10, 5'd9, 20'd9), 1'b1, 5'(13 + k),
                  {$random(seed), $random(seed)}, taken);
    end
    issue(encode(0, 5'd10, 5'd9, 20'd9), 0);

    // unknown opcode, ANDI and AND with bit 30, SLLI
    issue(32'h0000_0063, 0);
    issue(encode(12, 5'd4, 5'd1, 20'h00400), 0);
    issue(encode(8, 5'd4, 5'd1, 20'd2) | 32'h4000_0000, 0);
    issue({12'h003, 5'd1, 3'b001, 5'd4, opc_op_imm}, 0);

    for (int n = 0; n < n_random; n++) begin
      issue(encode($unsigned($random(seed)) % 14, 5'($random(seed)), 5'($random(seed)),
                   20'($random(seed))), 30);
    end

    repeat (2) drive_cycle(1'b0, '0, 1'b0, 5'd0, 64'd0, taken);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: testbench/tb_clkgen.sv
/*
 * testbench clock and reset
 * free-running clock and a synchronous reset held for a few cycles
 */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int period     = 20,
  parameter int rst_cycles = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: verilog/exec_top.sv
/*
 * rv64 execute slice top level
 * decode, register read and ALU in the accept cycle, with the
 * result and load responses sharing one write port
 */
`timescale 1ns/1ps

module exec_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               inst_valid,
  input  logic [rv_exec_pkg::inst_w-1:0]     inst,
  input  logic                               ld_valid,
  input  logic [rv_exec_pkg::reg_addr_w-1:0] ld_rd,
  input  logic [rv_exec_pkg::xlen-1:0]       ld_data,
  output logic                               busy,
  output logic                               inst_illegal,
  output logic                               wb_valid,
  output logic [rv_exec_pkg::reg_addr_w-1:0] wb_rd,
  output logic [rv_exec_pkg::xlen-1:0]       wb_data
);
  import rv_exec_pkg::*;

  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       imm;
  alu_op_e               alu_op;
  logic                  use_imm;
  logic                  illegal;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       operand_b;
  logic [xlen-1:0]       result;
  logic                  accept;

  assign accept       = inst_valid & ~busy;
  assign inst_illegal = accept & illegal;
  assign operand_b    = use_imm ? imm : rs2_data;

  inst_decode u_decode (
    .inst    (inst),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .imm     (imm),
    .alu_op  (alu_op),
    .use_imm (use_imm),
    .illegal (illegal)
  );

  // write port doubles as the commit report
  gpr_file #(.data_w(xlen)) u_gpr (
    .clk     (clk),
    .raddr_a (rs1),
    .raddr_b (rs2),
    .rdata_a (rs1_data),
    .rdata_b (rs2_data),
    .wen     (wb_valid),
    .waddr   (wb_rd),
    .wdata   (wb_data)
  );

  alu #(.data_w(xlen)) u_alu (
    .op     (alu_op),
    .a      (rs1_data),
    .b      (operand_b),
    .result (result)
  );

  wb_arbiter #(.data_w(xlen)) u_wb_arb (
    .clk       (clk),
    .rst       (rst),
    .alu_valid (accept & ~illegal),
    .alu_rd    (rd),
    .alu_data  (result),
    .ld_valid  (ld_valid),
    .ld_rd     (ld_rd),
    .ld_data   (ld_data),
    .wen       (wb_valid),
    .waddr     (wb_rd),
    .wdata     (wb_data),
    .busy      (busy)
  );

endmodule

// File: verilog/wb_arbiter.sv
/*
 * writeback arbiter
 * holds one ALU result in a slot and grants the register write port,
 * load responses first, then the slot
 */
`timescale 1ns/1ps

module wb_arbiter #(
  parameter int data_w = 64
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               alu_valid,
  input  logic [rv_exec_pkg::reg_addr_w-1:0] alu_rd,
  input  logic [data_w-1:0]                  alu_data,
  input  logic                               ld_valid,
  input  logic [rv_exec_pkg::reg_addr_w-1:0] ld_rd,
  input  logic [data_w-1:0]                  ld_data,
  output logic                               wen,
  output logic [rv_exec_pkg::reg_addr_w-1:0] waddr,
  output logic [data_w-1:0]                  wdata,
  output logic                               busy
);
  import rv_exec_pkg::*;

  logic                  slot_valid;
  logic [reg_addr_w-1:0] slot_rd;
  logic [data_w-1:0]     slot_data;
  logic                  slot_grant;

  // load always wins the port
  assign slot_grant = slot_valid & ~ld_valid;

  assign wen   = ld_valid | slot_valid;
  assign waddr = ld_valid ? ld_rd : slot_rd;
  assign wdata = ld_valid ? ld_data : slot_data;

  // slot full and the port taken by a load
  assign busy = slot_valid & ld_valid;

  // a new result may land in the same edge the old one retires
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_valid <= 1'b0;
    end else if (alu_valid) begin
      slot_valid <= 1'b1;
    end else if (slot_grant) begin
      slot_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (alu_valid) begin
      slot_rd   <= alu_rd;
      slot_data <= alu_data;
    end
  end

endmodule

// File: verilog/gpr_file.sv
/*
 * general purpose register file
 * 32 entries, two asynchronous read ports with write-through
 * forwarding, one write port, x0 hard-wired to zero
 */
`timescale 1ns/1ps

module gpr_file #(
  parameter int data_w = 64
) (
  input  logic                               clk,
  input  logic [rv_exec_pkg::reg_addr_w-1:0] raddr_a,
  input  logic [rv_exec_pkg::reg_addr_w-1:0] raddr_b,
  output logic [data_w-1:0]                  rdata_a,
  output logic [data_w-1:0]                  rdata_b,
  input  logic                               wen,
  input  logic [rv_exec_pkg::reg_addr_w-1:0] waddr,
  input  logic [data_w-1:0]                  wdata
);
  import rv_exec_pkg::*;

  localparam int nr_regs = 1 << reg_addr_w;

  logic [data_w-1:0] regs [nr_regs];
  logic              fwd_a;
  logic              fwd_b;

  // bypass the value being written this cycle
  assign fwd_a = wen && (waddr == raddr_a);
  assign fwd_b = wen && (waddr == raddr_b);

  assign rdata_a = (raddr_a == '0) ? '0 : fwd_a ? wdata : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 : fwd_b ? wdata : regs[raddr_b];

  // x0 writes are dropped
  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

// File: verilog/alu.sv
/*
 * integer ALU
 * combinational add, sub, logic, logical shifts and set-less-than,
 * plus a pass of operand b for LUI
 */
`timescale 1ns/1ps

module alu #(
  parameter int data_w = 64
) (
  input  rv_exec_pkg::alu_op_e op,
  input  logic [data_w-1:0]    a,
  input  logic [data_w-1:0]    b,
  output logic [data_w-1:0]    result
);
  import rv_exec_pkg::*;

  localparam int sh_w = $clog2(data_w);

  logic [sh_w-1:0] shamt;
  logic            lt_signed;
  logic            lt_unsigned;

  // shift amount from the low bits of b only
  assign shamt       = b[sh_w-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      alu_slt:    result = {{(data_w-1){1'b0}}, lt_signed};
      alu_sltu:   result = {{(data_w-1){1'b0}}, lt_unsigned};
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

endmodule

// File: verilog/inst_decode.sv
/*
 * instruction decoder
 * splits an RV64 instruction into register fields, classifies it,
 * selects the ALU operation and forms the I or U immediate
 */
`timescale 1ns/1ps

module inst_decode (
  input  logic [rv_exec_pkg::inst_w-1:0]     inst,
  output logic [rv_exec_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_exec_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_exec_pkg::reg_addr_w-1:0] rd,
  output logic [rv_exec_pkg::xlen-1:0]       imm,
  output rv_exec_pkg::alu_op_e               alu_op,
  output logic                               use_imm,
  output logic                               illegal
);
  import rv_exec_pkg::*;

  // opcode to class table
  localparam logic [6:0] cls_keys [3] = '{opc_op, opc_op_imm, opc_lui};
  localparam inst_class_e cls_vals [3] = '{cls_reg, cls_imm, cls_lui};

  // {is_imm, bit 30, funct3} to operation
  localparam logic [4:0] op_keys [13] = '{
    5'b0_0_000, 5'b0_1_000, 5'b0_0_001, 5'b0_0_010, 5'b0_0_011,
    5'b0_0_100, 5'b0_0_101, 5'b0_0_110, 5'b0_0_111,
    5'b1_0_000, 5'b1_0_100, 5'b1_0_110, 5'b1_0_111
  };
  localparam alu_op_e op_vals [13] = '{
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_or,  alu_and,
    alu_add, alu_xor, alu_or,  alu_and
  };

  inst_class_e cls;
  alu_op_e     funct_op;
  logic        funct_hit;
  logic        is_imm;
  logic        key_b30;
  logic [2:0]  funct3;

  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];

  key_lookup #(.data_t(inst_class_e), .nr_key(3), .key_w(7)) u_cls_lookup (
    .key           (inst[6:0]),
    .keys          (cls_keys),
    .values        (cls_vals),
    .default_value (cls_bad),
    .value         (cls),
    .hit           ()
  );

  // bit 30 is immediate data for ADDI, so it is masked out of the key;
  // on the immediate logic ops it stays in and then matches nothing
  assign is_imm  = (cls == cls_imm);
  assign key_b30 = inst[30] & ~(is_imm & (funct3 == 3'b000));

  key_lookup #(.data_t(alu_op_e), .nr_key(13), .key_w(5)) u_op_lookup (
    .key           ({is_imm, key_b30, funct3}),
    .keys          (op_keys),
    .values        (op_vals),
    .default_value (alu_add),
    .value         (funct_op),
    .hit           (funct_hit)
  );

  assign alu_op  = (cls == cls_lui) ? alu_pass_b : funct_op;
  assign use_imm = (cls != cls_reg);
  assign imm     = (cls == cls_lui) ? {{32{inst[31]}}, inst[31:12], 12'b0}
                                    : {{52{inst[31]}}, inst[31:20]};
  assign illegal = (cls == cls_bad) | ((cls != cls_lui) & ~funct_hit);

endmodule

// File: verilog/key_lookup.sv
/*
 * key_lookup
 * compares a key against a table of keys and returns the matching
 * value, or a default value when no entry matches
 */
`timescale 1ns/1ps

module key_lookup #(
  parameter type data_t = logic,
  parameter int  nr_key = 2,
  parameter int  key_w  = 1
) (
  input  logic [key_w-1:0] key,
  input  logic [key_w-1:0] keys [nr_key],
  input  data_t            values [nr_key],
  input  data_t            default_value,
  output data_t            value,
  output logic             hit
);

  data_t match_or;
  logic  any_match;

  // or together every matching entry
  always_comb begin
    match_or  = data_t'(0);
    any_match = 1'b0;
    for (int i = 0; i < nr_key; i++) begin
      if (key == keys[i]) begin
        match_or  = data_t'(match_or | values[i]);
        any_match = 1'b1;
      end
    end
  end

  assign hit   = any_match;
  assign value = any_match ? match_or : default_value;

endmodule

// File: verilog/rv_exec_pkg.sv
/*
 * rv64 execute slice shared definitions
 * data and index widths, major opcodes and the decoded-operation enums
 * used by the decoder, the ALU and the top level
 */
package rv_exec_pkg;

  // datapath widths
  localparam int xlen       = 64;
  localparam int reg_addr_w = 5;
  localparam int inst_w     = 32;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;

  // instruction class from the major opcode
  typedef enum logic [1:0] {
    cls_reg,
    cls_imm,
    cls_lui,
    cls_bad
  } inst_class_e;

  // ALU operation
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_slt,
    alu_sltu,
    // result is operand b, used by LUI
    alu_pass_b
  } alu_op_e;

endpackage
